/* hw/cta_table_pkg.sv */
`default_nettype none

package cta_table_pkg;

    // Table geometry
    localparam int MAX_NUM_CTA  = 4;
    localparam int THREAD_WIDTH = 256;
    localparam int THREAD_SHIFT = $clog2(THREAD_WIDTH);
    localparam int CTA_IDX_W    = $clog2(MAX_NUM_CTA);
    // Slot count runs from 0 to MAX_NUM_CTA inclusive
    localparam int SPAN_W       = $clog2(MAX_NUM_CTA + 1);

    // Descriptor field widths
    localparam int CTA_ID_W   = 16;
    localparam int CTA_SIZE_W = 11;

    typedef logic [CTA_IDX_W-1:0]   cta_idx_t;
    typedef logic [SPAN_W-1:0]      slot_span_t;
    typedef logic [MAX_NUM_CTA-1:0] slot_mask_t;

    // CTA descriptor, carried from add port through slot to output buffer
    typedef struct packed {
        logic [CTA_ID_W-1:0]   cta_id_x;
        logic [CTA_ID_W-1:0]   cta_id_y;
        logic [CTA_ID_W-1:0]   cta_id_z;
        logic [CTA_SIZE_W-1:0] cta_size;
        logic [CTA_ID_W-1:0]   kernel_id;
    } cta_desc_t;

    // One table slot
    typedef struct packed {
        logic       valid;
        logic       is_primary;
        slot_span_t span;
        cta_desc_t  desc;
    } slot_entry_t;

endpackage

`default_nettype wire

/* hw/cta_slot_alloc.sv */
`timescale 1ns/1ns
`default_nettype none

module cta_slot_alloc (
    input  cta_table_pkg::slot_mask_t         valid_mask,
    input  logic [cta_table_pkg::CTA_SIZE_W-1:0] add_size,
    output cta_table_pkg::cta_idx_t           free_index,
    output logic                              any_free,
    output cta_table_pkg::slot_span_t         span_needed
);
    import cta_table_pkg::*;

    logic [CTA_SIZE_W:0] size_rounded;
    logic [CTA_SIZE_W:0] span_full;

    // Lowest free slot wins
    always_comb begin
        free_index = '0;
        any_free   = 1'b0;
        for (int i = 0; i < MAX_NUM_CTA; i++) begin
            if (!valid_mask[i] && !any_free) begin
                free_index = CTA_IDX_W'(i);
                any_free   = 1'b1;
            end
        end
    end

    // Ceiling of add_size / THREAD_WIDTH, one extra bit keeps the carry
    assign size_rounded = {1'b0, add_size} + (CTA_SIZE_W + 1)'(THREAD_WIDTH - 1);
    assign span_full    = size_rounded >> THREAD_SHIFT;
    assign span_needed  = span_full[SPAN_W-1:0];

    // Shift-based division only holds for a power-of-two slot width
    initial begin
        assert ((THREAD_WIDTH & (THREAD_WIDTH - 1)) == 0)
            else $fatal(1, "THREAD_WIDTH %0d is not a power of two", THREAD_WIDTH);
    end

endmodule

`default_nettype wire

/* hw/cta_slot_array.sv */
`timescale 1ns/1ns
`default_nettype none

module cta_slot_array (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      add_en,
    input  cta_table_pkg::cta_idx_t   add_index,
    input  cta_table_pkg::slot_span_t add_span,
    input  cta_table_pkg::cta_desc_t  add_desc,
    input  logic                      pop_valid,
    input  cta_table_pkg::cta_idx_t   pop_index,
    input  logic                      pop_take,
    output logic                      pop_hit,
    output cta_table_pkg::cta_desc_t  pop_desc,
    output cta_table_pkg::slot_mask_t valid_mask,
    output cta_table_pkg::slot_mask_t primary_mask
);
    import cta_table_pkg::*;

    slot_entry_t slot_q [MAX_NUM_CTA];

    slot_span_t pop_span;
    slot_mask_t add_mask;
    slot_mask_t pop_mask;

    // Lookup of the addressed slot
    assign pop_hit  = pop_valid && slot_q[pop_index].valid;
    assign pop_desc = slot_q[pop_index].desc;
    assign pop_span = slot_q[pop_index].span;

    always_comb begin
        for (int j = 0; j < MAX_NUM_CTA; j++) begin
            valid_mask[j]   = slot_q[j].valid;
            primary_mask[j] = slot_q[j].valid && slot_q[j].is_primary;
        end
    end

    // Slot runs touched by this cycle's add and pop
    always_comb begin
        add_mask = '0;
        pop_mask = '0;
        for (int j = 0; j < MAX_NUM_CTA; j++) begin
            if (j >= int'(add_index) && j < int'(add_index) + int'(add_span)) begin
                add_mask[j] = add_en;
            end
            if (j >= int'(pop_index) && j < int'(pop_index) + int'(pop_span)) begin
                pop_mask[j] = pop_take;
            end
        end
    end

    // An add and a pop never share a slot, so both can land in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < MAX_NUM_CTA; j++) begin
                slot_q[j].valid      <= 1'b0;
                slot_q[j].is_primary <= 1'b0;
                slot_q[j].span       <= '0;
            end
        end else begin
            for (int j = 0; j < MAX_NUM_CTA; j++) begin
                if (pop_mask[j]) begin
                    slot_q[j].valid      <= 1'b0;
                    slot_q[j].is_primary <= 1'b0;
                    slot_q[j].span       <= '0;
                end else if (add_mask[j]) begin
                    slot_q[j].valid      <= 1'b1;
                    slot_q[j].is_primary <= (j == int'(add_index));
                    // Every slot of the run keeps the span for the later clear
                    slot_q[j].span       <= add_span;
                    if (j == int'(add_index)) begin
                        slot_q[j].desc <= add_desc;
                    end
                end
            end
        end
    end

    // Upstream only sends adds that fit behind the first free slot
    property p_add_fits;
        @(posedge clk) disable iff (!rst_n)
        add_en |-> ((int'(add_index) + int'(add_span) <= MAX_NUM_CTA) &&
                    ((add_mask & valid_mask) == '0));
    endproperty
    a_add_fits: assert property (p_add_fits)
        else $error("Add run at slot %0d span %0d overlaps or overruns", add_index, add_span);

    // Output buffer may only take a pop this array reported as a hit
    property p_take_needs_hit;
        @(posedge clk) disable iff (!rst_n)
        pop_take |-> pop_hit;
    endproperty
    a_take_needs_hit: assert property (p_take_needs_hit)
        else $error("pop_take without pop_hit at slot %0d", pop_index);

endmodule

`default_nettype wire

/* hw/cta_out_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module cta_out_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pop_hit,
    input  cta_table_pkg::cta_desc_t pop_desc,
    input  logic                     out_ready,
    output logic                     pop_take,
    output logic                     out_valid,
    output cta_table_pkg::cta_desc_t out_desc
);
    import cta_table_pkg::*;

    cta_desc_t desc_q;

    // Room when empty or when the held entry leaves this cycle
    assign pop_take = pop_hit && (!out_valid || out_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (pop_take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Descriptor register
    always_ff @(posedge clk) begin
        if (pop_take) begin
            desc_q <= pop_desc;
        end
    end

    assign out_desc = desc_q;

endmodule

`default_nettype wire

/* hw/active_cta_table.sv */
`timescale 1ns/1ns
`default_nettype none

module active_cta_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      add_valid,
    input  cta_table_pkg::cta_desc_t  add_desc,
    input  logic                      pop_valid,
    input  cta_table_pkg::cta_idx_t   pop_hw_cta_id,
    input  logic                      out_ready,
    output logic                      add_ready,
    output logic                      out_valid,
    output cta_table_pkg::cta_desc_t  out_desc,
    output cta_table_pkg::slot_mask_t cta_valid,
    output logic                      full,
    output cta_table_pkg::cta_idx_t   next_empty_cta_index
);
    import cta_table_pkg::*;

    slot_mask_t valid_mask;
    slot_mask_t primary_mask;
    cta_idx_t   free_index;
    slot_span_t span_needed;
    cta_desc_t  pop_desc;
    logic       any_free;
    logic       add_en;
    logic       pop_hit;
    logic       pop_take;

    // Any free slot accepts an add, fit is left to upstream
    assign add_ready            = any_free;
    assign full                 = !any_free;
    assign add_en               = add_valid && add_ready;
    assign next_empty_cta_index = free_index;
    assign cta_valid            = primary_mask;

    cta_slot_alloc u_alloc (
        .valid_mask  (valid_mask),
        .add_size    (add_desc.cta_size),
        .free_index  (free_index),
        .any_free    (any_free),
        .span_needed (span_needed)
    );

    cta_slot_array u_slots (
        .clk          (clk),
        .rst_n        (rst_n),
        .add_en       (add_en),
        .add_index    (free_index),
        .add_span     (span_needed),
        .add_desc     (add_desc),
        .pop_valid    (pop_valid),
        .pop_index    (pop_hw_cta_id),
        .pop_take     (pop_take),
        .pop_hit      (pop_hit),
        .pop_desc     (pop_desc),
        .valid_mask   (valid_mask),
        .primary_mask (primary_mask)
    );

    cta_out_buffer u_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop_hit   (pop_hit),
        .pop_desc  (pop_desc),
        .out_ready (out_ready),
        .pop_take  (pop_take),
        .out_valid (out_valid),
        .out_desc  (out_desc)
    );

endmodule

`default_nettype wire

/* test/active_cta_table_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module active_cta_table_tb;
    import cta_table_pkg::*;

    localparam string STIM_FILE = "test/cta_table_stim.txt";
    localparam int    CLK_HALF  = 2;

    // One stimulus line: the operation, its operands and the status one cycle later
    typedef struct packed {
        logic       do_add;
        logic       do_pop;
        cta_desc_t  desc;
        cta_idx_t   pop_idx;
        logic       ready;
        slot_mask_t exp_mask;
        logic       exp_full;
        cta_idx_t   exp_next;
        logic       exp_oval;
        cta_desc_t  exp_desc;
    } stim_row_t;

    logic       clk;
    logic       rst_n;
    logic       add_valid;
    cta_desc_t  add_desc;
    logic       pop_valid;
    cta_idx_t   pop_hw_cta_id;
    logic       out_ready;
    logic       add_ready;
    logic       out_valid;
    cta_desc_t  out_desc;
    slot_mask_t cta_valid;
    logic       full;
    cta_idx_t   next_empty_cta_index;

    stim_row_t rows[$];
    int        desc_errors  = 0;
    int        mask_errors  = 0;
    int        index_errors = 0;
    int        other_errors = 0;
    int        cycles       = 0;
    int        cycle_limit  = 50;

    active_cta_table dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .add_valid            (add_valid),
        .add_desc             (add_desc),
        .pop_valid            (pop_valid),
        .pop_hw_cta_id        (pop_hw_cta_id),
        .out_ready            (out_ready),
        .add_ready            (add_ready),
        .out_valid            (out_valid),
        .out_desc             (out_desc),
        .cta_valid            (cta_valid),
        .full                 (full),
        .next_empty_cta_index (next_empty_cta_index)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Run limit follows the number of stimulus lines
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Simulation ran past %0d cycles without finishing", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic load_stim();
        int          fd;
        int          count;
        int          line_no;
        string       line;
        string       op_word;
        logic [15:0] x, y, z, kid, ex, ey, ez, ekid;
        logic [10:0] sz, esz;
        cta_idx_t    idx, nxt;
        logic        rdy, efull, eoval;
        slot_mask_t  emask;
        stim_row_t   row;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %s", STIM_FILE);
            other_errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            line_no++;
            if (line.len() == 0 || line.getc(0) == "#") continue;
            count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            op_word, x, y, z, sz, kid, idx, rdy,
                            emask, efull, nxt, eoval, ex, ey, ez, esz, ekid);
            // Blank lines
            if (count <= 0) continue;
            if (count != 17) begin
                $display("Stimulus line %0d has %0d fields instead of 17", line_no, count);
                other_errors++;
                continue;
            end
            row = '0;
            if (op_word == "add") begin
                row.do_add = 1'b1;
            end else if (op_word == "pop") begin
                row.do_pop = 1'b1;
            end else if (op_word == "both") begin
                row.do_add = 1'b1;
                row.do_pop = 1'b1;
            end else if (op_word != "drain" && op_word != "idle") begin
                $display("Stimulus line %0d has unknown operation %s", line_no, op_word);
                other_errors++;
                continue;
            end
            row.desc     = '{cta_id_x: x, cta_id_y: y, cta_id_z: z, cta_size: sz, kernel_id: kid};
            row.pop_idx  = idx;
            row.ready    = rdy;
            row.exp_mask = emask;
            row.exp_full = efull;
            row.exp_next = nxt;
            row.exp_oval = eoval;
            row.exp_desc = '{cta_id_x: ex, cta_id_y: ey, cta_id_z: ez, cta_size: esz,
                             kernel_id: ekid};
            rows.push_back(row);
        end
        $fclose(fd);
    endtask

    task automatic drive_row(input stim_row_t row);
        add_valid     = row.do_add;
        add_desc      = row.desc;
        pop_valid     = row.do_pop;
        pop_hw_cta_id = row.pop_idx;
        out_ready     = row.ready;
    endtask

    task automatic check_mask(input int row_no, input slot_mask_t exp_mask,
                              input slot_mask_t act_mask);
        if (act_mask !== exp_mask) begin
            mask_errors++;
            $display("Error at %0t ns: cta_valid expected %b actual %b (row %0d)",
                     $time, exp_mask, act_mask, row_no);
        end
    endtask

    // add_ready is the inverse of full by the table's rule
    task automatic check_index(input int row_no, input cta_idx_t exp_idx, input logic exp_full,
                               input cta_idx_t act_idx, input logic act_full,
                               input logic act_ready);
        if (act_idx !== exp_idx) begin
            index_errors++;
            $display("Error at %0t ns: next_empty_cta_index expected %0d actual %0d (row %0d)",
                     $time, exp_idx, act_idx, row_no);
        end
        if (act_full !== exp_full) begin
            index_errors++;
            $display("Error at %0t ns: full expected %b actual %b (row %0d)",
                     $time, exp_full, act_full, row_no);
        end
        if (act_ready !== !exp_full) begin
            index_errors++;
            $display("Error at %0t ns: add_ready expected %b actual %b (row %0d)",
                     $time, !exp_full, act_ready, row_no);
        end
    endtask

    task automatic check_desc(input int row_no, input logic exp_valid, input cta_desc_t exp_desc,
                              input logic act_valid, input cta_desc_t act_desc);
        if (act_valid !== exp_valid) begin
            desc_errors++;
            $display("Error at %0t ns: out_valid expected %b actual %b (row %0d)",
                     $time, exp_valid, act_valid, row_no);
        end else if (exp_valid && act_desc !== exp_desc) begin
            desc_errors++;
            $display("Error at %0t ns: out_desc expected %h actual %h (row %0d)",
                     $time, exp_desc, act_desc, row_no);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        add_valid     = 1'b0;
        add_desc      = '0;
        pop_valid     = 1'b0;
        pop_hw_cta_id = '0;
        out_ready     = 1'b0;
        load_stim();
        cycle_limit = rows.size() * 4 + 50;
        if (rows.size() == 0) begin
            $display("No stimulus lines were loaded");
            other_errors++;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Empty table straight out of reset
        check_mask(0, '0, cta_valid);
        check_index(0, '0, 1'b0, next_empty_cta_index, full, add_ready);
        check_desc(0, 1'b0, '0, out_valid, out_desc);
        foreach (rows[i]) begin
            drive_row(rows[i]);
            @(posedge clk);
            #1;
            check_mask(i + 1, rows[i].exp_mask, cta_valid);
            check_index(i + 1, rows[i].exp_next, rows[i].exp_full,
                        next_empty_cta_index, full, add_ready);
            check_desc(i + 1, rows[i].exp_oval, rows[i].exp_desc, out_valid, out_desc);
        end
        add_valid = 1'b0;
        pop_valid = 1'b0;
        $display("Error counts: desc %0d, mask %0d, index %0d, other %0d",
                 desc_errors, mask_errors, index_errors, other_errors);
        if (desc_errors + mask_errors + index_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/cta_table_stim.txt */
# op x y z size kernel pop_idx out_ready, then expected one cycle later:
# cta_valid full next_idx out_valid out_x out_y out_z out_size out_kernel (all hex)
# Span rounding, 100 threads then 600 threads
add   0001 0002 0003 064 00a1 0 1   1 0 1 0   0000 0000 0000 000 0000
add   0010 0011 0012 258 00b2 0 1   3 1 0 0   0000 0000 0000 000 0000
# Pop slot 1 into the empty buffer
pop   0000 0000 0000 000 0000 1 1   1 0 1 1   0010 0011 0012 258 00b2
# Stalled consumer, pop of slot 0 ignored
pop   0000 0000 0000 000 0000 0 0   1 0 1 1   0010 0011 0012 258 00b2
idle  0000 0000 0000 000 0000 0 0   1 0 1 1   0010 0011 0012 258 00b2
drain 0000 0000 0000 000 0000 0 1   1 0 1 0   0000 0000 0000 000 0000
# Pop of a free slot
pop   0000 0000 0000 000 0000 2 1   1 0 1 0   0000 0000 0000 000 0000
# Refill up to full
add   0020 0021 0022 100 00c3 0 1   3 0 2 0   0000 0000 0000 000 0000
add   0030 0031 0032 200 00d4 0 1   7 1 0 0   0000 0000 0000 000 0000
pop   0000 0000 0000 000 0000 0 0   6 0 0 1   0001 0002 0003 064 00a1
# Add and pop together while the buffer drains
both  0005 0006 0007 0c8 00e1 2 1   3 0 2 1   0030 0031 0032 200 00d4
pop   0000 0000 0000 000 0000 1 1   1 0 1 1   0020 0021 0022 100 00c3
pop   0000 0000 0000 000 0000 0 0   1 0 1 1   0020 0021 0022 100 00c3
drain 0000 0000 0000 000 0000 0 1   1 0 1 0   0000 0000 0000 000 0000
pop   0000 0000 0000 000 0000 3 1   1 0 1 0   0000 0000 0000 000 0000
# Three slot run, then an add refused while full
add   0040 0041 0042 300 00e5 0 1   3 1 0 0   0000 0000 0000 000 0000
add   0060 0061 0062 001 00ff 0 1   3 1 0 0   0000 0000 0000 000 0000
pop   0000 0000 0000 000 0000 1 1   1 0 1 1   0040 0041 0042 300 00e5
pop   0000 0000 0000 000 0000 0 1   0 0 0 1   0005 0006 0007 0c8 00e1
drain 0000 0000 0000 000 0000 0 1   0 0 0 0   0000 0000 0000 000 0000
# Largest CTA takes the whole table
add   0050 0051 0052 400 00f6 0 1   1 1 0 0   0000 0000 0000 000 0000
pop   0000 0000 0000 000 0000 0 1   0 0 0 1   0050 0051 0052 400 00f6
idle  0000 0000 0000 000 0000 0 0   0 0 0 1   0050 0051 0052 400 00f6
drain 0000 0000 0000 000 0000 0 1   0 0 0 0   0000 0000 0000 000 0000

/* compile.f */
hw/cta_table_pkg.sv
hw/cta_slot_alloc.sv
hw/cta_slot_array.sv
hw/cta_out_buffer.sv
hw/active_cta_table.sv
test/active_cta_table_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the active CTA table testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -sv -f compile.f \
    --top-module active_cta_table_tb -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi
exit 0
